// ==== files.f ====
verilog/usb_wake_pkg.sv
verilog/usb_glitch_filter.sv
verilog/usb_line_monitor.sv
verilog/usb_pullup_hold.sv
verilog/usb_wake_ctrl.sv
verilog/usb_aon_wake_top.sv
tb/tb_clk_gen.sv
tb/usb_aon_wake_chk.sv
tb/usb_aon_wake_tb.sv

// ==== tb/usb_aon_wake_tb.sv ====
`timescale 1ns/10ps

module usb_aon_wake_tb;

  // Upper bound from a pin change to its filtered event
  localparam int LATENCY_BOUND  = 8;
  localparam int HOLD_CYCLES    = 10;
  localparam int SETTLE_CYCLES  = 10;
  localparam int HIST_MAX       = 512;
  localparam int MIN_CHECKS     = 150;
  localparam int CHECK_DELAY_NS = 10;
  localparam int WAKE_BIT       = 3;
  // Six phases of at most about 200 cycles each, plus margin
  localparam int TIMEOUT_CYCLES = 6 * 200 + 300;

  logic clk_aon;
  logic rst_aon_n;
  logic usb_dp;
  logic usb_dn;
  logic usb_sense;
  logic core_dp_pu;
  logic core_dn_pu;
  logic wake_ack;
  logic suspend_req;
  logic dp_pu_out;
  logic dn_pu_out;
  logic wake_req;
  logic bus_not_idle;
  logic bus_reset;
  logic sense_lost;
  logic detect_active;

  // Expected side of the block
  usb_wake_pkg::wake_state_e exp_state;
  logic                      frozen_dp;
  logic                      frozen_dn;
  logic [3:0]                exp_status;
  // Each entry is {dp, dn, sense, dp pull-up, dn pull-up} for one cycle while active
  logic [4:0]                pin_hist [HIST_MAX];
  int                        hist_len;
  logic                      check_pending;
  int                        checks_done;
  int                        cycle_count;
  integer                    seed;

  tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) u_clk_gen (
    .clk_o (clk_aon),
    .rst_no(rst_aon_n)
  );

  usb_aon_wake_top u_dut (
    .clk_aon_i               (clk_aon),
    .rst_aon_ni              (rst_aon_n),
    .usb_dp_i                (usb_dp),
    .usb_dn_i                (usb_dn),
    .usb_sense_i             (usb_sense),
    .usbdev_dppullup_en_i    (core_dp_pu),
    .usbdev_dnpullup_en_i    (core_dn_pu),
    .wake_ack_aon_i          (wake_ack),
    .suspend_req_aon_i       (suspend_req),
    .usb_dppullup_en_o       (dp_pu_out),
    .usb_dnpullup_en_o       (dn_pu_out),
    .wake_req_aon_o          (wake_req),
    .bus_not_idle_aon_o      (bus_not_idle),
    .bus_reset_aon_o         (bus_reset),
    .sense_lost_aon_o        (sense_lost),
    .wake_detect_active_aon_o(detect_active)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  // Expected {wake, flags} from the line history of the current active period
  function automatic logic [3:0] expected_status(input usb_wake_pkg::wake_state_e state,
                                                 input int depth);
    logic [3:0] status;
    logic [2:0] raw;
    int         run [3];
    int         need;
    int         i;
    int         e;
    status = 4'b0000;
    run = '{0, 0, 0};
    for (i = 0; i < depth; i++) begin
      // Any pin that disagrees with its pull-up is bus activity
      raw[usb_wake_pkg::EV_NOT_IDLE]   = (pin_hist[i][4] != pin_hist[i][1]) |
                                         (pin_hist[i][3] != pin_hist[i][0]);
      raw[usb_wake_pkg::EV_BUS_RESET]  = ~pin_hist[i][4] & ~pin_hist[i][3];
      raw[usb_wake_pkg::EV_SENSE_LOST] = ~pin_hist[i][2];
      for (e = 0; e < 3; e++) begin
        need = (e == usb_wake_pkg::EV_NOT_IDLE) ? usb_wake_pkg::IDLE_FILTER_CYCLES :
                                                  usb_wake_pkg::EVENT_FILTER_CYCLES;
        run[e] = raw[e] ? run[e] + 1 : 0;
        // A stable run counts once its start lies a full latency bound back
        if ((run[e] == need) && ((depth - 1 - (i + 1 - need)) >= LATENCY_BOUND)) begin
          status[e] = 1'b1;
        end
      end
    end
    status[WAKE_BIT] = |status[2:0];
    if (state != usb_wake_pkg::WAKE_ACTIVE) begin
      status = 4'b0000;
    end
    return status;
  endfunction

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic check_event(input usb_wake_pkg::wake_event_e ev, input logic actual,
                             input logic expected);
    string name;
    case (ev)
      usb_wake_pkg::EV_NOT_IDLE:  name = "bus_not_idle_aon_o";
      usb_wake_pkg::EV_BUS_RESET: name = "bus_reset_aon_o";
      default:                    name = "sense_lost_aon_o";
    endcase
    check_bit(name, actual, expected);
  endtask

  task automatic check_state(input usb_wake_pkg::wake_state_e actual,
                             input usb_wake_pkg::wake_state_e expected);
    if (actual !== expected) begin
      abort_run($sformatf("** Error: wake_detect_active_aon_o = 0x%0h, expected 0x%0h",
                          actual, expected));
    end
  endtask

  // Logs the cycle just driven, optionally asks for a compare, and moves to the next falling edge
  task automatic step(input logic check);
    if (exp_state == usb_wake_pkg::WAKE_ACTIVE) begin
      if (hist_len == HIST_MAX) begin
        abort_run("The pin history buffer overflowed");
      end
      pin_hist[hist_len] = {usb_dp, usb_dn, usb_sense, frozen_dp, frozen_dn};
      hist_len++;
    end
    check_pending = check;
    @(negedge clk_aon);
  endtask

  task automatic hold_line(input logic dp, input logic dn, input logic sense,
                           input int cycles, input logic check);
    usb_dp    = dp;
    usb_dn    = dn;
    usb_sense = sense;
    repeat (cycles) step(check);
  endtask

  // Walks the core pull-ups through all four patterns, then parks them at J
  task automatic toggle_core(input int cycles);
    logic [1:0] pat;
    pat = 2'b00;
    repeat (cycles) begin
      {core_dp_pu, core_dn_pu} = pat;
      step(1'b1);
      pat = pat + 2'b01;
    end
    core_dp_pu = 1'b1;
    core_dn_pu = 1'b0;
  endtask

  task automatic wait_state(input usb_wake_pkg::wake_state_e target, input int max_cycles);
    int waited;
    waited = 0;
    while (usb_wake_pkg::wake_state_e'(detect_active) !== target) begin
      if (waited == max_cycles) begin
        abort_run($sformatf("The controller did not change state within %0d cycles", waited));
      end
      @(negedge clk_aon);
      waited++;
    end
    // The hold stage freezes whatever the core drove when the state moved
    exp_state = target;
    frozen_dp = core_dp_pu;
    frozen_dn = core_dn_pu;
    hist_len  = 0;
  endtask

  // Short K, SE0 or sense drops, each followed by a quiet J gap
  task automatic glitch_burst(input int count);
    int kind;
    int len;
    repeat (count) begin
      kind = $unsigned($random(seed)) % 3;
      len  = 1 + $unsigned($random(seed)) % 2;
      hold_line(kind == 2, kind == 0, kind != 2, len, 1'b1);
      hold_line(1'b1, 1'b0, 1'b1, 5, 1'b1);
    end
  endtask

  // Samples a quarter period after the rising edge, clear of both clock edges
  always @(posedge clk_aon) begin
    #(CHECK_DELAY_NS);
    if (check_pending) begin
      exp_status = expected_status(exp_state, hist_len);
      check_state(usb_wake_pkg::wake_state_e'(detect_active), exp_state);
      check_event(usb_wake_pkg::EV_NOT_IDLE, bus_not_idle, exp_status[usb_wake_pkg::EV_NOT_IDLE]);
      check_event(usb_wake_pkg::EV_BUS_RESET, bus_reset, exp_status[usb_wake_pkg::EV_BUS_RESET]);
      check_event(usb_wake_pkg::EV_SENSE_LOST, sense_lost,
                  exp_status[usb_wake_pkg::EV_SENSE_LOST]);
      check_bit("wake_req_aon_o", wake_req, exp_status[WAKE_BIT]);
      check_bit("usb_dppullup_en_o", dp_pu_out,
                (exp_state == usb_wake_pkg::WAKE_ACTIVE) ? frozen_dp : core_dp_pu);
      check_bit("usb_dnpullup_en_o", dn_pu_out,
                (exp_state == usb_wake_pkg::WAKE_ACTIVE) ? frozen_dn : core_dn_pu);
      check_pending = 1'b0;
      checks_done++;
    end
  end

  always @(posedge clk_aon) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: the test hung and was stopped after %0d cycles",
                          TIMEOUT_CYCLES));
    end
  end

  initial begin
    seed          = 32'hb8006264;
    usb_dp        = 1'b1;
    usb_dn        = 1'b0;
    usb_sense     = 1'b1;
    core_dp_pu    = 1'b1;
    core_dn_pu    = 1'b0;
    wake_ack      = 1'b0;
    suspend_req   = 1'b0;
    exp_state     = usb_wake_pkg::WAKE_IDLE;
    frozen_dp     = 1'b0;
    frozen_dn     = 1'b0;
    hist_len      = 0;
    check_pending = 1'b0;
    checks_done   = 0;
    cycle_count   = 0;
    @(posedge rst_aon_n);
    @(negedge clk_aon);

    // Reset values, then the core drives the pads straight through
    hold_line(1'b1, 1'b0, 1'b1, 2, 1'b1);
    toggle_core(8);
    hold_line(1'b1, 1'b0, 1'b1, 12, 1'b1);

    // Suspend with the line in J, core pull-up changes must not reach the pads
    suspend_req = 1'b1;
    wait_state(usb_wake_pkg::WAKE_ACTIVE, 4);
    suspend_req = 1'b0;
    toggle_core(8);

    glitch_burst(20);

    // Resume K, then a bus reset SE0, each followed by a return to J
    hold_line(1'b0, 1'b1, 1'b1, HOLD_CYCLES, 1'b0);
    hold_line(1'b1, 1'b0, 1'b1, SETTLE_CYCLES, 1'b0);
    hold_line(1'b1, 1'b0, 1'b1, 3, 1'b1);
    hold_line(1'b0, 1'b0, 1'b1, HOLD_CYCLES, 1'b0);
    hold_line(1'b1, 1'b0, 1'b1, SETTLE_CYCLES, 1'b0);
    hold_line(1'b1, 1'b0, 1'b1, 3, 1'b1);

    // VBUS drops away
    hold_line(1'b1, 1'b0, 1'b0, HOLD_CYCLES, 1'b0);
    hold_line(1'b1, 1'b0, 1'b1, SETTLE_CYCLES, 1'b0);
    hold_line(1'b1, 1'b0, 1'b1, 3, 1'b1);

    // The core takes back control and events while idle leave no trace
    wake_ack = 1'b1;
    wait_state(usb_wake_pkg::WAKE_IDLE, 4);
    wake_ack = 1'b0;
    hold_line(1'b1, 1'b0, 1'b1, 2, 1'b1);
    toggle_core(4);
    hold_line(1'b0, 1'b1, 1'b1, HOLD_CYCLES, 1'b1);
    hold_line(1'b0, 1'b0, 1'b1, HOLD_CYCLES, 1'b1);
    hold_line(1'b1, 1'b0, 1'b0, HOLD_CYCLES, 1'b1);
    hold_line(1'b1, 1'b0, 1'b1, SETTLE_CYCLES, 1'b1);

    if (checks_done >= MIN_CHECKS) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run($sformatf("Only %0d compares ran, fewer than the %0d expected",
                          checks_done, MIN_CHECKS));
    end
  end

endmodule

// ==== tb/usb_aon_wake_chk.sv ====
`timescale 1ns/10ps

module usb_aon_wake_chk (
  input logic       clk_aon_i,
  input logic       rst_aon_ni,
  input logic       active_i,
  input logic       wake_req_i,
  input logic [2:0] flags_i,
  input logic       dppullup_en_i,
  input logic       dnpullup_en_i
);

  usb_wake_pkg::wake_state_e state;

  // The debug output carries the controller state one to one
  assign state = usb_wake_pkg::wake_state_e'(active_i);

  // A wake request only comes out of a monitoring cycle
  wake_req_after_active: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    wake_req_i |-> ($past(state) == usb_wake_pkg::WAKE_ACTIVE))
    else $error("wake request raised without an active state before it");

  // Idle clears every sticky output on the next edge
  idle_clears_flags: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    (state == usb_wake_pkg::WAKE_IDLE) |=> ((flags_i == 3'b000) && !wake_req_i))
    else $error("flags or wake request still set one cycle into idle");

  // Once the hold has taken over the pads see a frozen pull-up pair
  pullups_frozen: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    ((state == usb_wake_pkg::WAKE_ACTIVE) && ($past(state) == usb_wake_pkg::WAKE_ACTIVE))
    |-> $stable({dppullup_en_i, dnpullup_en_i}))
    else $error("pull-up outputs moved while the block was active");

  state_known: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    !$isunknown(active_i))
    else $error("controller state is unknown");

endmodule

bind usb_aon_wake_top usb_aon_wake_chk u_chk (
  .clk_aon_i    (clk_aon_i),
  .rst_aon_ni   (rst_aon_ni),
  .active_i     (wake_detect_active_aon_o),
  .wake_req_i   (wake_req_aon_o),
  .flags_i      ({sense_lost_aon_o, bus_reset_aon_o, bus_not_idle_aon_o}),
  .dppullup_en_i(usb_dppullup_en_o),
  .dnpullup_en_i(usb_dnpullup_en_o)
);

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 40,
  parameter int unsigned RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset leaves on a falling edge, half a period away from the active edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== verilog/usb_aon_wake_top.sv ====
`timescale 1ns/10ps

module usb_aon_wake_top (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,

  // Pads
  input  logic usb_dp_i,
  input  logic usb_dn_i,
  input  logic usb_sense_i,

  // Pull-up enables from the main USB core
  input  logic usbdev_dppullup_en_i,
  input  logic usbdev_dnpullup_en_i,

  // Core register levels, already in the always-on domain
  input  logic wake_ack_aon_i,
  input  logic suspend_req_aon_i,

  // Pull-up enables that must survive low-power mode
  output logic usb_dppullup_en_o,
  output logic usb_dnpullup_en_o,

  // Wake request and the events behind it
  output logic wake_req_aon_o,
  output logic bus_not_idle_aon_o,
  output logic bus_reset_aon_o,
  output logic sense_lost_aon_o,

  // Debug view of the controller state
  output logic wake_detect_active_aon_o
);

  logic ev_not_idle;
  logic ev_bus_reset;
  logic ev_sense_lost;
  logic wake_active;

  // The monitor compares the pins with the pull-ups that are really on the pads
  // so the hold stage outputs loop back here
  usb_line_monitor u_line_monitor (
    .clk_aon_i      (clk_aon_i),
    .rst_aon_ni     (rst_aon_ni),
    .usb_dp_i       (usb_dp_i),
    .usb_dn_i       (usb_dn_i),
    .usb_sense_i    (usb_sense_i),
    .dppullup_en_i  (usb_dppullup_en_o),
    .dnpullup_en_i  (usb_dnpullup_en_o),
    .ev_not_idle_o  (ev_not_idle),
    .ev_bus_reset_o (ev_bus_reset),
    .ev_sense_lost_o(ev_sense_lost)
  );

  usb_pullup_hold u_pullup_hold (
    .clk_aon_i           (clk_aon_i),
    .rst_aon_ni          (rst_aon_ni),
    .usbdev_dppullup_en_i(usbdev_dppullup_en_i),
    .usbdev_dnpullup_en_i(usbdev_dnpullup_en_i),
    .wake_active_i       (wake_active),
    .usb_dppullup_en_o   (usb_dppullup_en_o),
    .usb_dnpullup_en_o   (usb_dnpullup_en_o)
  );

  usb_wake_ctrl u_wake_ctrl (
    .clk_aon_i         (clk_aon_i),
    .rst_aon_ni        (rst_aon_ni),
    .ev_not_idle_i     (ev_not_idle),
    .ev_bus_reset_i    (ev_bus_reset),
    .ev_sense_lost_i   (ev_sense_lost),
    .suspend_req_aon_i (suspend_req_aon_i),
    .wake_ack_aon_i    (wake_ack_aon_i),
    .wake_active_o     (wake_active),
    .wake_req_aon_o    (wake_req_aon_o),
    .bus_not_idle_aon_o(bus_not_idle_aon_o),
    .bus_reset_aon_o   (bus_reset_aon_o),
    .sense_lost_aon_o  (sense_lost_aon_o)
  );

  // The controller state doubles as the debug output
  assign wake_detect_active_aon_o = wake_active;

endmodule

// ==== verilog/usb_wake_ctrl.sv ====
`timescale 1ns/10ps

module usb_wake_ctrl (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,

  // Filtered events from the line monitor
  input  logic ev_not_idle_i,
  input  logic ev_bus_reset_i,
  input  logic ev_sense_lost_i,

  // Register levels from the core, already in the always-on domain
  input  logic suspend_req_aon_i,
  input  logic wake_ack_aon_i,

  // State as a level for the pull-up hold stage and for debug
  output logic wake_active_o,

  // Wake request to the power manager
  output logic wake_req_aon_o,

  // Sticky record of what was seen while monitoring
  output logic bus_not_idle_aon_o,
  output logic bus_reset_aon_o,
  output logic sense_lost_aon_o
);

  usb_wake_pkg::wake_state_e state_d;
  usb_wake_pkg::wake_state_e state_q;

  logic                                ctrl_active;
  logic [usb_wake_pkg::NUM_EVENTS-1:0] events;
  logic [usb_wake_pkg::NUM_EVENTS-1:0] flags_d;
  logic [usb_wake_pkg::NUM_EVENTS-1:0] flags_q;
  logic                                wake_req_d;
  logic                                wake_req_q;

  // Gather the events in wake_event_e order
  always_comb begin
    events = '0;
    events[usb_wake_pkg::EV_NOT_IDLE]   = ev_not_idle_i;
    events[usb_wake_pkg::EV_BUS_RESET]  = ev_bus_reset_i;
    events[usb_wake_pkg::EV_SENSE_LOST] = ev_sense_lost_i;
  end

  // Hand-over FSM
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // Core owns the pull-ups until it asks for suspend
      usb_wake_pkg::WAKE_IDLE: begin
        if (suspend_req_aon_i) begin
          state_d = usb_wake_pkg::WAKE_ACTIVE;
        end
      end
      // Monitoring until the core acknowledges the wake
      usb_wake_pkg::WAKE_ACTIVE: begin
        if (wake_ack_aon_i) begin
          state_d = usb_wake_pkg::WAKE_IDLE;
        end
      end
      default: begin
        state_d = usb_wake_pkg::WAKE_IDLE;
      end
    endcase
  end

  assign ctrl_active = (state_q == usb_wake_pkg::WAKE_ACTIVE);

  // Flags set on their event and hold while active
  // Leaving active clears them all on the next edge
  assign flags_d = {usb_wake_pkg::NUM_EVENTS{ctrl_active}} & (events | flags_q);

  // Any event during monitoring requests a wake, and the request sticks
  assign wake_req_d = ctrl_active & ((|events) | wake_req_q);

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      state_q    <= usb_wake_pkg::WAKE_IDLE;
      flags_q    <= '0;
      wake_req_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      flags_q    <= flags_d;
      wake_req_q <= wake_req_d;
    end
  end

  assign wake_active_o      = ctrl_active;
  assign wake_req_aon_o     = wake_req_q;
  assign bus_not_idle_aon_o = flags_q[usb_wake_pkg::EV_NOT_IDLE];
  assign bus_reset_aon_o    = flags_q[usb_wake_pkg::EV_BUS_RESET];
  assign sense_lost_aon_o   = flags_q[usb_wake_pkg::EV_SENSE_LOST];

endmodule

// ==== verilog/usb_pullup_hold.sv ====
`timescale 1ns/10ps

module usb_pullup_hold (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,

  // Pull-up enables from the main USB core, in its own clock domain
  input  logic usbdev_dppullup_en_i,
  input  logic usbdev_dnpullup_en_i,

  // High while this block owns the pull-ups
  input  logic wake_active_i,

  // Pull-up enables towards the pads
  output logic usb_dppullup_en_o,
  output logic usb_dnpullup_en_o
);

  logic [1:0] core_en_meta_q;
  logic [1:0] core_en_sync_q;
  logic [1:0] held_en_q;
  logic       hold_sel;

  // Interpret the controller level as its state
  assign hold_sel = (usb_wake_pkg::wake_state_e'(wake_active_i) ==
                     usb_wake_pkg::WAKE_ACTIVE);

  // Bring the core enables into the always-on domain, bit 1 is D+ and bit 0 is D-
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      core_en_meta_q <= 2'b00;
      core_en_sync_q <= 2'b00;
    end else begin
      core_en_meta_q <= {usbdev_dppullup_en_i, usbdev_dnpullup_en_i};
      core_en_sync_q <= core_en_meta_q;
    end
  end

  // The held copy tracks the core while idle
  // and freezes the moment the controller takes over
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      held_en_q <= 2'b00;
    end else if (!hold_sel) begin
      held_en_q <= core_en_sync_q;
    end
  end

  // While idle the core drives the pads directly with no added delay
  // While active the frozen copy keeps the line in J even if the core powers down
  assign usb_dppullup_en_o = hold_sel ? held_en_q[1] : usbdev_dppullup_en_i;
  assign usb_dnpullup_en_o = hold_sel ? held_en_q[0] : usbdev_dnpullup_en_i;

endmodule

// ==== verilog/usb_line_monitor.sv ====
`timescale 1ns/10ps

module usb_line_monitor (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,

  // Bus and VBUS sense pins, asynchronous
  input  logic usb_dp_i,
  input  logic usb_dn_i,
  input  logic usb_sense_i,

  // Pull-up enables as they are currently driven onto the pins
  input  logic dppullup_en_i,
  input  logic dnpullup_en_i,

  // Filtered event levels
  output logic ev_not_idle_o,
  output logic ev_bus_reset_o,
  output logic ev_sense_lost_o
);

  logic not_idle_raw;
  logic se0_raw;
  logic sense_lost_raw;

  // While suspended only the device pull-up sets the line level
  // so any pin that disagrees with its pull-up means the host is driving
  // This catches resume (J to K) as well as reset (J to SE0)
  // Comparing against the pull-ups also absorbs any pin swap
  assign not_idle_raw = (usb_dp_i != dppullup_en_i) |
                        (usb_dn_i != dnpullup_en_i);

  // Both lines low is SE0, a bus reset once it lasts
  assign se0_raw = ~usb_dp_i & ~usb_dn_i;

  // VBUS sense low means the cable has been pulled
  assign sense_lost_raw = ~usb_sense_i;

  // Longer window on activity, it also filters line noise
  usb_glitch_filter #(
    .CYCLES(usb_wake_pkg::IDLE_FILTER_CYCLES)
  ) u_filter_not_idle (
    .clk_aon_i (clk_aon_i),
    .rst_aon_ni(rst_aon_ni),
    .filter_i  (not_idle_raw),
    .filter_o  (ev_not_idle_o)
  );

  usb_glitch_filter #(
    .CYCLES(usb_wake_pkg::EVENT_FILTER_CYCLES)
  ) u_filter_bus_reset (
    .clk_aon_i (clk_aon_i),
    .rst_aon_ni(rst_aon_ni),
    .filter_i  (se0_raw),
    .filter_o  (ev_bus_reset_o)
  );

  usb_glitch_filter #(
    .CYCLES(usb_wake_pkg::EVENT_FILTER_CYCLES)
  ) u_filter_sense_lost (
    .clk_aon_i (clk_aon_i),
    .rst_aon_ni(rst_aon_ni),
    .filter_i  (sense_lost_raw),
    .filter_o  (ev_sense_lost_o)
  );

endmodule

// ==== verilog/usb_glitch_filter.sv ====
`timescale 1ns/10ps

module usb_glitch_filter #(
  parameter int unsigned CYCLES = 4
) (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,
  input  logic filter_i,
  output logic filter_o
);

  // Counter wide enough to reach CYCLES-1, also for CYCLES of 1
  localparam int unsigned CNT_W = $clog2(CYCLES + 1);

  logic [usb_wake_pkg::SYNC_STAGES-1:0] sync_q;
  logic                                 sync_val;
  logic                                 stored_q;
  logic [CNT_W-1:0]                     stable_cnt_q;
  logic                                 stable_hit;
  logic                                 filter_q;

  // Shift the asynchronous input through the synchronizer chain
  // Bit 0 takes the pin, the top bit is the first safe sample
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[usb_wake_pkg::SYNC_STAGES-2:0], filter_i};
    end
  end

  assign sync_val = sync_q[usb_wake_pkg::SYNC_STAGES-1];

  // The count restarts whenever the synchronized value moves
  // and saturates once the value has been seen long enough
  assign stable_hit = (stable_cnt_q == CNT_W'(CYCLES - 1));

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      stored_q     <= 1'b0;
      stable_cnt_q <= '0;
      filter_q     <= 1'b0;
    end else begin
      stored_q <= sync_val;
      if (sync_val != stored_q) begin
        stable_cnt_q <= '0;
      end else if (!stable_hit) begin
        stable_cnt_q <= stable_cnt_q + 1'b1;
      end
      // Only a value that survived the whole window reaches the output
      if (stable_hit) begin
        filter_q <= stored_q;
      end
    end
  end

  assign filter_o = filter_q;

endmodule

// ==== verilog/usb_wake_pkg.sv ====
package usb_wake_pkg;

  // Controller state
  // In WAKE_IDLE the USB core drives the pull-ups
  // In WAKE_ACTIVE this block holds them and watches the bus
  typedef enum logic {
    WAKE_IDLE   = 1'b0,
    WAKE_ACTIVE = 1'b1
  } wake_state_e;

  // Index of each monitored event, also the bit order of the sticky flag vector
  typedef enum logic [1:0] {
    EV_NOT_IDLE   = 2'd0,
    EV_BUS_RESET  = 2'd1,
    EV_SENSE_LOST = 2'd2
  } wake_event_e;

  // Number of events in the flag vector
  localparam int unsigned NUM_EVENTS = 3;

  // Synchronizer depth in front of every filter
  localparam int unsigned SYNC_STAGES = 2;

  // The always-on clock is slow, so 4 cycles already give a long debounce
  // and leave the main core time to see a resume on its own
  localparam int unsigned IDLE_FILTER_CYCLES = 4;

  // SE0 and VBUS loss only need a short debounce
  localparam int unsigned EVENT_FILTER_CYCLES = 3;

endpackage
